// File: frame_store_top.f
hdl/frame_store_pkg.sv
hdl/display_fifo.sv
hdl/sdram_ctrl.sv
hdl/frame_buffer_arbiter.sv
hdl/frame_store_top.sv
sim/sdram_model.sv
sim/frame_store_properties.sv
sim/tb_frame_store.sv

// File: hdl/display_fifo.sv
module display_fifo import frame_store_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       push,
	input  pixel_t     din,
	input  logic       pop,
	output pixel_t     dout,
	output logic       empty,
	output logic [4:0] free
);

	pixel_t             mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic [FIFO_AW:0]   count_next;
	logic               do_push;
	logic               do_pop;

	assign free = 5'(FIFO_DEPTH) - count;
	assign do_push = push && (free != '0);
	assign do_pop = pop && !empty;
	assign dout = mem[rd_ptr];  // fwft

	always_comb begin
		count_next = count;
		if (do_push && !do_pop) begin
			count_next = count + 1'b1;
		end else if (do_pop && !do_push) begin
			count_next = count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			empty <= 1'b1;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			empty <= (count_next == '0);
		end
	end

endmodule

// File: hdl/frame_buffer_arbiter.sv
module frame_buffer_arbiter import frame_store_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [9:0] cam_level,
	input  pixel_t     cam_data,
	input  region_e    cam_region,
	output logic       rd_camera,
	input  logic       scan_en,
	input  region_e    view,
	input  logic [4:0] fifo_free,
	input  logic       ready,
	output logic       req_valid,
	output mem_req_t   req,
	input  logic       wr_strobe,
	output pixel_t     wr_data
);

	arb_state_e       state;
	logic             pend;      // request built, not yet taken
	mem_req_t         req_q;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             want_write;
	logic             want_read;

	// filtered frame sits FRAME_BLOCKS blocks above raw
	function automatic logic [BLOCK_AW-1:0] block_addr(
		input region_e          r,
		input logic [PTR_W-1:0] p
	);
		logic [BLOCK_AW-1:0] base;
		base = (r == filtered) ? BLOCK_AW'(FRAME_BLOCKS) : '0;
		return base + BLOCK_AW'(p);
	endfunction

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		logic [PTR_W-1:0] n;
		n = (p == PTR_W'(FRAME_BLOCKS - 1)) ? '0 : p + 1'b1;
		return n;
	endfunction

	assign want_write = cam_level >= 10'(BURST_LEN);
	assign want_read = scan_en && (fifo_free >= 5'(BURST_LEN));

	assign req_valid = pend && ready;
	assign req = req_q;

	// camera fifo is fwft, word is on cam_data in the strobe cycle
	assign rd_camera = wr_strobe;
	assign wr_data = cam_data;

	// writes win over reads
	always_ff @(posedge clk) begin
		if (state == arb_idle && ready) begin
			if (want_write) begin
				req_q.write <= 1'b1;
				req_q.block <= block_addr(cam_region, wr_ptr);
			end else if (want_read) begin
				req_q.write <= 1'b0;
				req_q.block <= block_addr(view, rd_ptr);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= arb_idle;
			pend <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			case (state)
				arb_idle: begin
					if (ready && want_write) begin
						pend <= 1'b1;
						state <= arb_write_wait;
					end else if (ready && want_read) begin
						pend <= 1'b1;
						state <= arb_read_wait;
					end
				end
				arb_write_wait: begin
					if (req_valid) begin
						pend <= 1'b0;
						wr_ptr <= next_ptr(wr_ptr);
					end else if (!pend && ready) begin  // burst done
						state <= arb_idle;
					end
				end
				arb_read_wait: begin
					if (req_valid) begin
						pend <= 1'b0;
						rd_ptr <= next_ptr(rd_ptr);
					end else if (!pend && ready) begin
						state <= arb_idle;
					end
				end
				default: begin
					pend <= 1'b0;
					state <= arb_idle;
				end
			endcase
		end
	end

endmodule

// File: hdl/frame_store_pkg.sv
package frame_store_pkg;

	localparam int BURST_LEN = 8;          // words per burst and per camera block
	localparam int FRAME_BLOCKS = 16;      // blocks per frame region
	localparam int BLOCK_AW = 6;           // bank in [1:0], row above
	localparam int CAS_LAT = 2;
	localparam int REFRESH_INTERVAL = 400;
	localparam int INIT_WAIT = 20;
	localparam int FIFO_DEPTH = 16;

	localparam int PTR_W = $clog2(FRAME_BLOCKS);
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(INIT_WAIT + 1);
	localparam int REF_W = $clog2(REFRESH_INTERVAL);
	localparam int T_RFC = 4;              // idle cycles after a refresh command

	// burst length 1, sequential, cas latency in a6:a4
	localparam logic [12:0] MODE_WORD = 13'(CAS_LAT << 4);
	localparam logic [12:0] PRECHARGE_ALL = 13'h0400; // a10 high, all banks

	typedef logic [15:0] pixel_t;

	typedef enum logic {raw, filtered} region_e;

	// encoding is the pin pattern {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		cmd_nop       = 4'b0111,
		cmd_active    = 4'b0011,
		cmd_read      = 4'b0101,
		cmd_write     = 4'b0100,
		cmd_precharge = 4'b0010,
		cmd_refresh   = 4'b0001,
		cmd_load_mode = 4'b0000
	} sdram_cmd_e;

	typedef struct packed {
		logic        cke;
		logic        cs_n;
		logic        ras_n;
		logic        cas_n;
		logic        we_n;
		logic [12:0] addr;
		logic [1:0]  ba;
	} sdram_bus_t;

	typedef struct packed {
		logic                write;
		logic [BLOCK_AW-1:0] block;
	} mem_req_t;

	typedef enum logic [1:0] {arb_idle, arb_write_wait, arb_read_wait} arb_state_e;

	typedef enum logic [3:0] {
		init_wait, init_pre, init_ref, init_mode, idle,
		activate, burst, cas_wait, precharge, refresh
	} ctrl_state_e;

endpackage

// File: hdl/frame_store_top.sv
module frame_store_top import frame_store_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [9:0] cam_level,
	input  pixel_t     cam_data,
	input  region_e    cam_region,
	output logic       rd_camera,
	input  logic       scan_en,
	input  region_e    view,
	input  logic       pop,
	output pixel_t     dout,
	output logic       empty,
	output sdram_bus_t sdram,
	inout  pixel_t     sdram_dq
);

	logic       req_valid;
	mem_req_t   req;
	logic       ready;
	logic       wr_strobe;
	pixel_t     wr_data;
	logic       rd_valid;
	pixel_t     rd_data;
	logic [4:0] fifo_free;

	frame_buffer_arbiter u_arbiter (
		.clk        (clk),
		.rst_n      (rst_n),
		.cam_level  (cam_level),
		.cam_data   (cam_data),
		.cam_region (cam_region),
		.rd_camera  (rd_camera),
		.scan_en    (scan_en),
		.view       (view),
		.fifo_free  (fifo_free),
		.ready      (ready),
		.req_valid  (req_valid),
		.req        (req),
		.wr_strobe  (wr_strobe),
		.wr_data    (wr_data)
	);

	sdram_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.ready     (ready),
		.wr_strobe (wr_strobe),
		.wr_data   (wr_data),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.sdram     (sdram),
		.sdram_dq  (sdram_dq)
	);

	// read returns go straight into the display buffer
	display_fifo u_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (rd_valid),
		.din   (rd_data),
		.pop   (pop),
		.dout  (dout),
		.empty (empty),
		.free  (fifo_free)
	);

endmodule

// File: hdl/sdram_ctrl.sv
module sdram_ctrl import frame_store_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       req_valid,
	input  mem_req_t   req,
	output logic       ready,
	output logic       wr_strobe,
	input  pixel_t     wr_data,
	output logic       rd_valid,
	output pixel_t     rd_data,
	output sdram_bus_t sdram,
	inout  pixel_t     sdram_dq
);

	ctrl_state_e        state;
	logic [CNT_W-1:0]   cnt;
	logic [REF_W-1:0]   ref_cnt;
	logic               refresh_due;
	mem_req_t           req_q;
	sdram_cmd_e         cmd_q;
	logic               cke_q;
	logic [12:0]        addr_q;
	logic [1:0]         ba_q;
	pixel_t             dq_out;
	logic               dq_oe;
	logic [CAS_LAT-1:0] rd_pipe;   // one bit per read still in flight

	assign ready = (state == idle) && !refresh_due;
	assign wr_strobe = (state == burst) && req_q.write;

	// cke, then the four command pins, then addr and ba
	assign sdram = {cke_q, cmd_q, addr_q, ba_q};
	assign sdram_dq = dq_oe ? dq_out : 'z;

	assign rd_valid = rd_pipe[CAS_LAT-1];
	assign rd_data = sdram_dq;  // chip drives dq while rd_valid is high

	// refresh timer, due flag cleared when idle takes it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ref_cnt <= '0;
			refresh_due <= 1'b0;
		end else begin
			if (state == idle && refresh_due) begin
				refresh_due <= 1'b0;
			end
			if (ref_cnt == REF_W'(REFRESH_INTERVAL - 1)) begin
				ref_cnt <= '0;
				refresh_due <= 1'b1;
			end else begin
				ref_cnt <= ref_cnt + 1'b1;
			end
		end
	end

	// a read on the bus now returns CAS_LAT edges later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pipe <= '0;
		end else begin
			rd_pipe <= {rd_pipe[CAS_LAT-2:0], cmd_q == cmd_read};
		end
	end

	always_ff @(posedge clk) begin
		if (wr_strobe) begin
			dq_out <= wr_data;
		end
		if (ready && req_valid) begin
			req_q <= req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= init_wait;
			cnt <= '0;
			cmd_q <= cmd_nop;
			cke_q <= 1'b0;
			addr_q <= '0;
			ba_q <= '0;
			dq_oe <= 1'b0;
		end else begin
			cmd_q <= cmd_nop;
			dq_oe <= 1'b0;
			cnt <= cnt + 1'b1;
			case (state)
				init_wait: begin
					if (cnt == CNT_W'(INIT_WAIT - 1)) begin
						cke_q <= 1'b1;
						cmd_q <= cmd_precharge;
						addr_q <= PRECHARGE_ALL;
						cnt <= '0;
						state <= init_pre;
					end
				end
				init_pre: begin
					cmd_q <= cmd_refresh;  // first of two
					cnt <= '0;
					state <= init_ref;
				end
				init_ref: begin
					if (cnt == CNT_W'(T_RFC - 1)) begin
						cmd_q <= cmd_refresh;
					end else if (cnt == CNT_W'(2 * T_RFC - 1)) begin
						cmd_q <= cmd_load_mode;
						addr_q <= MODE_WORD;
						ba_q <= '0;
						state <= init_mode;
					end
				end
				init_mode: state <= idle;
				idle: begin
					if (refresh_due) begin
						cmd_q <= cmd_refresh;
						cnt <= '0;
						state <= refresh;
					end else if (req_valid) begin
						cmd_q <= cmd_active;
						addr_q <= 13'(req.block[BLOCK_AW-1:2]);  // row
						ba_q <= req.block[1:0];
						state <= activate;
					end
				end
				activate: begin
					cnt <= '0;
					state <= burst;
				end
				burst: begin
					cmd_q <= req_q.write ? cmd_write : cmd_read;
					addr_q <= 13'(cnt);  // column is the word index
					ba_q <= req_q.block[1:0];
					dq_oe <= req_q.write;
					if (cnt == CNT_W'(BURST_LEN - 1)) begin
						cnt <= '0;
						state <= req_q.write ? precharge : cas_wait;
					end
				end
				cas_wait: begin
					if (cnt == CNT_W'(CAS_LAT)) begin  // last word captured
						cnt <= '0;
						state <= precharge;
					end
				end
				precharge: begin
					if (cnt == '0) begin
						cmd_q <= cmd_precharge;
						addr_q <= PRECHARGE_ALL;
					end else begin
						state <= idle;
					end
				end
				refresh: begin
					if (cnt == CNT_W'(T_RFC - 1)) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_frame_store \
	-f frame_store_top.f -o tb_frame_store

./obj_dir/tb_frame_store > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
grep -q "PASS: all tests" sim.log

// File: sim/frame_store_golden.txt
# C region w0..w7 = camera burst, S view blocks = scan, E w0..w7 = expected display words
# W = wait until traffic settles, F flag = expected empty; region 0 raw, 1 filtered
C 0 A000 A001 A002 A003 A004 A005 A006 A007
C 0 A010 A011 A012 A013 A014 A015 A016 A017
C 0 A020 A021 A022 A023 A024 A025 A026 A027
C 0 A030 A031 A032 A033 A034 A035 A036 A037
S 0 4
E A000 A001 A002 A003 A004 A005 A006 A007
E A010 A011 A012 A013 A014 A015 A016 A017
E A020 A021 A022 A023 A024 A025 A026 A027
E A030 A031 A032 A033 A034 A035 A036 A037
W
C 1 F040 F041 F042 F043 F044 F045 F046 F047
C 1 F050 F051 F052 F053 F054 F055 F056 F057
S 1 2
E F040 F041 F042 F043 F044 F045 F046 F047
E F050 F051 F052 F053 F054 F055 F056 F057
W
C 0 C060 C061 C062 C063 C064 C065 C066 C067
C 0 C070 C071 C072 C073 C074 C075 C076 C077
S 0 2
W
F 0
E C060 C061 C062 C063 C064 C065 C066 C067
E C070 C071 C072 C073 C074 C075 C076 C077
C 0 D080 D081 D082 D083 D084 D085 D086 D087
C 0 D090 D091 D092 D093 D094 D095 D096 D097
C 0 D0A0 D0A1 D0A2 D0A3 D0A4 D0A5 D0A6 D0A7
C 0 D0B0 D0B1 D0B2 D0B3 D0B4 D0B5 D0B6 D0B7
C 0 D0C0 D0C1 D0C2 D0C3 D0C4 D0C5 D0C6 D0C7
C 0 D0D0 D0D1 D0D2 D0D3 D0D4 D0D5 D0D6 D0D7
C 0 D0E0 D0E1 D0E2 D0E3 D0E4 D0E5 D0E6 D0E7
C 0 D0F0 D0F1 D0F2 D0F3 D0F4 D0F5 D0F6 D0F7
C 0 E000 E001 E002 E003 E004 E005 E006 E007
C 0 E010 E011 E012 E013 E014 E015 E016 E017
S 0 10
E D080 D081 D082 D083 D084 D085 D086 D087
E D090 D091 D092 D093 D094 D095 D096 D097
E D0A0 D0A1 D0A2 D0A3 D0A4 D0A5 D0A6 D0A7
E D0B0 D0B1 D0B2 D0B3 D0B4 D0B5 D0B6 D0B7
E D0C0 D0C1 D0C2 D0C3 D0C4 D0C5 D0C6 D0C7
E D0D0 D0D1 D0D2 D0D3 D0D4 D0D5 D0D6 D0D7
E D0E0 D0E1 D0E2 D0E3 D0E4 D0E5 D0E6 D0E7
E D0F0 D0F1 D0F2 D0F3 D0F4 D0F5 D0F6 D0F7
E E000 E001 E002 E003 E004 E005 E006 E007
E E010 E011 E012 E013 E014 E015 E016 E017
W

// File: sim/frame_store_properties.sv
module frame_store_properties (
	input logic       clk,
	input logic       rst_n,
	input logic       ready,
	input logic       req_valid,
	input logic       push,
	input logic [4:0] free,
	input logic       rd_camera,
	input logic [9:0] cam_level
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;  // read by the testbench

	// request only offered while the controller is idle, and taken at once
	req_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> ready ##1 !ready)
		else begin
			fail_count++;
			$error("req_valid without ready, or request not taken");
		end

	push_needs_room: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (free != '0))
		else begin
			fail_count++;
			$error("display fifo push with no free entry");
		end

	cam_read_needs_data: assert property (@(posedge clk) disable iff (!rst_n)
		rd_camera |-> (cam_level != '0))
		else begin
			fail_count++;
			$error("camera fifo read while empty");
		end

endmodule

// File: sim/sdram_model.sv
module sdram_model import frame_store_pkg::*; (
	input  logic       clk,
	input  sdram_bus_t sdram,
	inout  pixel_t     dq
);

	timeunit 1ns;
	timeprecision 1ps;

	pixel_t             mem [512];          // {bank, row[3:0], column[2:0]}
	logic [3:0]         open_row [4];
	logic [CAS_LAT-1:0] rd_v = '0;
	pixel_t             rd_d [CAS_LAT];
	sdram_cmd_e         cmd;
	int                 idx;

	assign cmd = sdram_cmd_e'({sdram.cs_n, sdram.ras_n, sdram.cas_n, sdram.we_n});
	assign idx = {sdram.ba, open_row[sdram.ba], sdram.addr[2:0]};

	// data returns on dq for one cycle, CAS_LAT cycles after the read
	assign dq = rd_v[CAS_LAT-1] ? rd_d[CAS_LAT-1] : 'z;

	initial begin
		foreach (mem[i]) begin
			mem[i] = pixel_t'(i * 16'h9e37) ^ 16'h5a5a;  // unwritten words look odd
		end
		foreach (open_row[i]) begin
			open_row[i] = '0;
		end
	end

	always @(posedge clk) begin
		if (sdram.cke) begin
			case (cmd)
				cmd_active: open_row[sdram.ba] <= sdram.addr[3:0];
				cmd_write: mem[idx] <= dq;
				default: ;
			endcase
		end
		rd_v <= {rd_v[CAS_LAT-2:0], sdram.cke && (cmd == cmd_read)};
		rd_d[0] <= mem[idx];
		for (int i = 1; i < CAS_LAT; i++) begin
			rd_d[i] <= rd_d[i-1];
		end
	end

endmodule

// File: sim/tb_frame_store.sv
module tb_frame_store import frame_store_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		region_e r;
		pixel_t  w;
	} cam_word_t;

	logic       clk;
	logic       rst_n = 1'b0;
	logic [9:0] cam_level = '0;
	pixel_t     cam_data = '0;
	region_e    cam_region = raw;
	logic       rd_camera;
	logic       scan_en = 1'b0;
	region_e    view = raw;
	logic       pop = 1'b0;
	pixel_t     dout;
	logic       empty;
	sdram_bus_t sdram;
	wire        [15:0] sdram_dq;

	cam_word_t  cam_q[$];       // camera fifo contents
	cam_word_t  wexp_q[$];      // words still expected on sdram writes
	string      lines[$];
	logic       loaded = 1'b0;
	logic       take = 1'b0;
	int         reads_seen = 0;
	int         scan_target = 0;
	int         since_ref = 0;  // cycles since the last refresh command
	region_e    scan_view = raw;
	logic [3:0] row_of [4];
	sdram_cmd_e cmd_now;

	frame_store_top uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.cam_level  (cam_level),
		.cam_data   (cam_data),
		.cam_region (cam_region),
		.rd_camera  (rd_camera),
		.scan_en    (scan_en),
		.view       (view),
		.pop        (pop),
		.dout       (dout),
		.empty      (empty),
		.sdram      (sdram),
		.sdram_dq   (sdram_dq)
	);

	sdram_model u_sdram (.clk(clk), .sdram(sdram), .dq(sdram_dq));

	bind frame_store_top frame_store_properties u_props (
		.clk       (clk),
		.rst_n     (rst_n),
		.ready     (ready),
		.req_valid (req_valid),
		.push      (rd_valid),
		.free      (fifo_free),
		.rd_camera (rd_camera),
		.cam_level (cam_level)
	);

	assign cmd_now = sdram_cmd_e'({sdram.cs_n, sdram.ras_n, sdram.cas_n, sdram.we_n});

	task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_region_word(input region_e got_r, input pixel_t got_w,
			input region_e exp_r, input pixel_t exp_w);
		if (got_r !== exp_r || got_w !== exp_w) begin
			$display("ERR %0t: sdram write got %s/%h expected %s/%h", $time,
				got_r.name(), got_w, exp_r.name(), exp_w);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_fields(input int got, input int want, input string line);
		if (got != want) begin
			$display("malformed line in golden file: %s", line);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic pop_word(input pixel_t exp);
		while (empty) @(negedge clk);
		check_pixel(dout, exp, "display word");
		pop = 1'b1;
		@(negedge clk);
		pop = 1'b0;
	endtask

	// all queued bursts written, scan finished, last reads landed
	task automatic wait_quiet();
		while (reads_seen < scan_target || cam_q.size() != 0 || wexp_q.size() != 0)
			@(negedge clk);
		repeat (CAS_LAT + 4) @(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// camera fifo, fwft, head consumed on each rd_camera
	always @(posedge clk) take <= rd_camera;

	always @(negedge clk) begin
		if (take && cam_q.size() != 0) void'(cam_q.pop_front());
		cam_level = 10'(cam_q.size());
		cam_data = (cam_q.size() != 0) ? cam_q[0].w : '0;
		cam_region = (cam_q.size() != 0) ? cam_q[0].r : raw;
	end

	always @(negedge clk) begin
		view = scan_view;
		scan_en = rst_n && (reads_seen < scan_target);
	end

	always @(negedge clk) begin
		if (uut.u_props.fail_count != 0) begin
			$display("bound assertion failed before %0t", $time);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	end

	// bus monitor, region is row bit 2 (block bit 4)
	always @(posedge clk) begin
		cam_word_t e;
		if (sdram.cke) begin
			if (cmd_now == cmd_refresh) since_ref = 0;
			else since_ref++;
			// a due refresh waits for one burst at most
			if (since_ref > REFRESH_INTERVAL + 4 * BURST_LEN) begin
				$display("no sdram refresh for %0d cycles at %0t", since_ref, $time);
				$display("FAIL: see errors above");
				$fatal(1);
			end
			if (cmd_now == cmd_active) row_of[sdram.ba] = sdram.addr[3:0];
			if (cmd_now == cmd_read) reads_seen++;
			if (cmd_now == cmd_write) begin
				if (wexp_q.size() == 0) begin
					$display("unexpected sdram write at %0t with no camera word queued", $time);
					$display("FAIL: see errors above");
					$fatal(1);
				end else begin
					e = wexp_q.pop_front();
					check_region_word(region_e'(row_of[sdram.ba][2]), sdram_dq, e.r, e.w);
				end
			end
		end
	end

	initial begin
		int limit;
		wait (loaded);
		limit = lines.size() * REFRESH_INTERVAL + INIT_WAIT;
		repeat (limit) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("FAIL: see errors above");
		$fatal(1);
	end

	initial begin
		int fd;
		string line;
		byte k;
		int r;
		int v;
		int nb;
		int n;
		pixel_t blk [BURST_LEN];
		fd = $fopen("sim/frame_store_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/frame_store_golden.txt");
			$display("FAIL: see errors above");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
		end
		$fclose(fd);
		loaded = 1'b1;

		// reset held 8 cycles, outputs quiet
		repeat (8) begin
			@(negedge clk);
			check_flag(rd_camera, 1'b0, "rd_camera in reset");
			check_flag(empty, 1'b1, "empty in reset");
			check_flag(cmd_now == cmd_nop, 1'b1, "nop in reset");
		end
		rst_n = 1'b1;
		repeat (INIT_WAIT - 2) begin
			@(negedge clk);
			check_flag(rd_camera, 1'b0, "rd_camera after reset");
			check_flag(empty, 1'b1, "empty after reset");
			check_flag(cmd_now == cmd_nop, 1'b1, "nop during power-up wait");
		end

		foreach (lines[i]) begin
			k = lines[i].getc(0);
			if (k == "C") begin
				n = $sscanf(lines[i], "C %d %h %h %h %h %h %h %h %h", r, blk[0], blk[1],
					blk[2], blk[3], blk[4], blk[5], blk[6], blk[7]);
				check_fields(n, BURST_LEN + 1, lines[i]);
				for (int j = 0; j < BURST_LEN; j++) begin
					cam_q.push_back({region_e'(r), blk[j]});
					wexp_q.push_back({region_e'(r), blk[j]});
				end
				@(negedge clk);
			end else if (k == "S") begin
				n = $sscanf(lines[i], "S %d %d", v, nb);
				check_fields(n, 2, lines[i]);
				scan_view = region_e'(v);
				scan_target += nb * BURST_LEN;
				@(negedge clk);
			end else if (k == "E") begin
				n = $sscanf(lines[i], "E %h %h %h %h %h %h %h %h", blk[0], blk[1],
					blk[2], blk[3], blk[4], blk[5], blk[6], blk[7]);
				check_fields(n, BURST_LEN, lines[i]);
				for (int j = 0; j < BURST_LEN; j++) pop_word(blk[j]);
			end else if (k == "W") begin
				wait_quiet();
			end else if (k == "F") begin
				n = $sscanf(lines[i], "F %d", v);
				check_fields(n, 1, lines[i]);
				check_flag(empty, v[0], "empty while pops held");
			end
		end
		wait_quiet();
		check_flag(empty, 1'b1, "display fifo drained");
		$display("PASS: all tests");
		$finish;
	end

endmodule
